/* ldpc_ibuf_top.f */
+incdir+dv
logic/ldpc_cfg_pkg.sv
logic/ldpc_buf_pkg.sv
logic/ldpc_buf_if.sv
logic/llr_block_writer.sv
logic/llr_pingpong_buffer.sv
logic/llr_block_reader.sv
logic/ldpc_ibuf_top.sv
dv/ldpc_ibuf_tb.sv

/* Bender.yml */
package:
  name: ldpc_ibuf

sources:
  - files:
      - logic/ldpc_cfg_pkg.sv
      - logic/ldpc_buf_pkg.sv
      - logic/ldpc_buf_if.sv
      - logic/llr_block_writer.sv
      - logic/llr_pingpong_buffer.sv
      - logic/llr_block_reader.sv
      - logic/ldpc_ibuf_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ldpc_ibuf_tb.sv

/* dv/ldpc_ibuf_tests.svh */
`ifndef LDPC_IBUF_TESTS_SVH
`define LDPC_IBUF_TESTS_SVH

// --------------------------------------------------
// stimulus helpers
// --------------------------------------------------
task automatic send_block(input tag_t tag, input int nwords, input bit gaps);
  int n;
  for (int i = 0; i < nwords; i++) begin
    if (gaps) begin
      stim_rng = xorshift(stim_rng);
      in_valid = 1'b0;
      repeat (stim_rng[1:0]) @(negedge iclk);   // 0..3 idle cycles
    end
    stim_rng = xorshift(stim_rng);
    in_valid = 1'b1;
    in_llr   = stim_rng[cWORD_W-1:0];
    in_tag   = tag;
    n        = 0;
    @(posedge iclk);
    while (!in_ready) begin        // stalled by a busy bank
      n++;
      if (n > max_wait) fail_timeout("in_ready");
      @(posedge iclk);
    end
    @(negedge iclk);
  end
  in_valid = 1'b0;
endtask

task automatic wait_words(input int target);
  int n;
  n = 0;
  while (words < target) begin
    n++;
    if (n > max_wait) fail_timeout("output words");
    @(negedge iclk);
  end
endtask

// all expected words out and all credits back
task automatic wait_drain();
  int n;
  n = 0;
  while (exp_q.size() != 0 || outstanding != 0) begin
    n++;
    if (n > max_wait) fail_timeout("drain");
    @(negedge iclk);
  end
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic single_block();
  int w0;
  test_name = "single_block";
  w0        = words;
  credit_on = 1'b1;
  send_block(8'h3c, cBLOCK_WORDS, 1'b0);
  wait_drain();
  check_eq("word count", cBLOCK_WORDS, words - w0);
endtask

task automatic credit_limit();
  int w0;
  test_name = "credit_limit";
  w0        = words;
  credit_on = 1'b0;               // hold all credits
  send_block(8'h5a, cBLOCK_WORDS, 1'b0);
  wait_words(w0 + cCREDITS);
  for (int i = 0; i < 50; i++) begin
    @(negedge iclk);
    check_eq("out_valid while starved", 0, out_valid);
  end
  check_eq("words before credits", cCREDITS, words - w0);
  credit_on = 1'b1;
  wait_drain();
  check_eq("word count", cBLOCK_WORDS, words - w0);
endtask

task automatic bank_backpressure();
  int a0;
  int w0;
  test_name = "bank_backpressure";
  a0        = acc;
  w0        = words;
  credit_on = 1'b0;
  send_block(8'ha1, cBLOCK_WORDS, 1'b0);
  send_block(8'ha2, cBLOCK_WORDS, 1'b0);
  in_valid = 1'b1;                // offer third block
  in_tag   = 8'ha3;
  for (int i = 0; i < 50; i++) begin
    @(negedge iclk);
    check_eq("in_ready with both banks full", 0, in_ready);
  end
  check_eq("accepted while full", 2 * cBLOCK_WORDS, acc - a0);
  credit_on = 1'b1;
  send_block(8'ha3, cBLOCK_WORDS, 1'b0);
  wait_drain();
  check_eq("word count", 3 * cBLOCK_WORDS, words - w0);
endtask

task automatic random_flow();
  int w0;
  test_name   = "random_flow";
  w0          = words;
  credit_on   = 1'b1;
  credit_rand = 1'b1;             // credits trickle back
  for (int b = 0; b < 3; b++) begin
    send_block(tag_t'(8'hc0 + b), cBLOCK_WORDS, 1'b1);
  end
  wait_drain();
  credit_rand = 1'b0;
  check_eq("word count", 3 * cBLOCK_WORDS, words - w0);
endtask

task automatic reset_recovery();
  int w0;
  test_name = "reset_recovery";
  w0        = words;
  credit_on = 1'b0;
  send_block(8'he1, cBLOCK_WORDS, 1'b0);
  send_block(8'he2, 10, 1'b0);    // second block cut short
  wait_words(w0 + cCREDITS);
  rst_n = 1'b0;
  for (int i = 0; i < 2; i++) begin
    @(negedge iclk);
    check_eq("out_valid in reset", 0, out_valid);
    check_eq("in_ready in reset", 0, in_ready);
  end
  rst_n     = 1'b1;
  w0        = words;
  credit_on = 1'b1;
  send_block(8'he3, cBLOCK_WORDS, 1'b0);
  wait_drain();
  check_eq("word count after reset", cBLOCK_WORDS, words - w0);
endtask

`endif

/* dv/ldpc_ibuf_tb.sv */
module ldpc_ibuf_tb
  import ldpc_cfg_pkg::*, ldpc_buf_pkg::*;
();

  // expected output word, built from the block rules
  typedef struct packed {
    llr_word_t llr;
    logic      par;
    logic      last;
    tag_t      tag;
  } exp_t;

  logic      iclk = 1'b0;
  logic      rst_n;
  logic      in_valid;
  logic      in_ready;
  llr_word_t in_llr;
  tag_t      in_tag;
  logic      out_valid;
  llr_word_t out_llr;
  logic      out_par;
  logic      out_last;
  tag_t      out_tag;
  logic      out_credit = 1'b0;

  exp_t        exp_q[$];          // reference model queue
  int          idx;               // word index of the block being accepted
  tag_t        blk_tag;
  int          outstanding;       // credits spent and not yet returned
  int          acc;               // accepted input words
  int          words;             // output words seen
  int          errors;
  int          timeouts;
  int unsigned max_wait = 2000;   // cycles per wait loop
  string       test_name = "reset";
  bit          credit_on;
  bit          credit_rand;
  logic [31:0] stim_rng;
  logic [31:0] cred_rng;

  ldpc_ibuf_top ldpc_ibuf_top_i (
    .iclk       (iclk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_llr     (in_llr),
    .in_tag     (in_tag),
    .out_valid  (out_valid),
    .out_llr    (out_llr),
    .out_par    (out_par),
    .out_last   (out_last),
    .out_tag    (out_tag),
    .out_credit (out_credit)
  );

  always #20 iclk = ~iclk;   // 40 unit period

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // --------------------------------------------------
  // reporting
  // --------------------------------------------------
  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("** Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic end_run();
    $display("errors %0d timeouts %0d words %0d", errors, timeouts, words);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout in %s while waiting for %s", test_name, what);
    timeouts++;
    end_run();
  endtask

  // pop one expected word and compare every field
  task automatic check_word();
    exp_t e;
    assert (exp_q.size() != 0) else begin
      $display("unexpected output word in %s, nothing was pending", test_name);
      errors++;
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      check_eq("out_llr", e.llr, out_llr);
      check_eq("out_par", e.par, out_par);
      check_eq("out_last", e.last, out_last);
      check_eq("out_tag", e.tag, out_tag);
    end
  endtask

  // --------------------------------------------------
  // reference model and monitor
  // --------------------------------------------------
  always @(posedge iclk or negedge rst_n) begin
    exp_t e;
    if (!rst_n) begin
      exp_q.delete();          // partial block is lost in reset
      idx         = 0;
      outstanding = 0;
    end else begin
      if (in_valid && in_ready) begin
        if (idx == 0) blk_tag = in_tag;
        e.llr  = (idx < cPUNCT_WORDS) ? '0 : in_llr;   // punctured words
        e.par  = (idx >= cDATA_WORDS);
        e.last = (idx == cBLOCK_WORDS - 1);
        e.tag  = blk_tag;
        exp_q.push_back(e);
        acc++;
        idx = (idx == cBLOCK_WORDS - 1) ? 0 : idx + 1;
      end
      outstanding = outstanding + out_valid - out_credit;
      if (out_valid) begin
        words++;
        check_word();
      end
    end
  end

  // credit return, never more than spent
  always @(negedge iclk) begin
    cred_rng   = xorshift(cred_rng);
    out_credit = rst_n && outstanding > 0 && credit_on && (!credit_rand || cred_rng[0]);
  end

  `include "ldpc_ibuf_tests.svh"

  initial begin
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_llr      = '0;
    in_tag      = '0;
    credit_on   = 1'b0;
    credit_rand = 1'b0;
    stim_rng    = 32'hea5d67c3;
    cred_rng    = xorshift(32'hea5d67c3);   // own stream for credits
    repeat (2) @(negedge iclk);
    rst_n = 1'b1;
    single_block();
    credit_limit();
    bank_backpressure();
    random_flow();
    reset_recovery();
    end_run();
  end

endmodule

/* logic/ldpc_ibuf_top.sv */
module ldpc_ibuf_top
  import ldpc_buf_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  // upstream, ready/valid
  input  logic      in_valid,
  output logic      in_ready,
  input  llr_word_t in_llr,
  input  tag_t      in_tag,
  // downstream, credit based
  output logic      out_valid,
  output llr_word_t out_llr,
  output logic      out_par,
  output logic      out_last,
  output tag_t      out_tag,
  input  logic      out_credit
);

  buf_wr_if wr_if ();
  buf_rd_if rd_if ();

  // ------------------------------------------------
  // producer, ping-pong store, consumer
  // ------------------------------------------------
  llr_block_writer writer_i (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_llr   (in_llr),
    .in_tag   (in_tag),
    .in_ready (in_ready),
    .wr       (wr_if.writer)
  );

  llr_pingpong_buffer buffer_i (
    .iclk  (iclk),
    .rst_n (rst_n),
    .wr    (wr_if.buffer),
    .rd    (rd_if.buffer)
  );

  llr_block_reader reader_i (
    .iclk       (iclk),
    .rst_n      (rst_n),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_par    (out_par),
    .out_last   (out_last),
    .out_llr    (out_llr),
    .out_tag    (out_tag),
    .rd         (rd_if.reader)
  );

endmodule

/* logic/llr_block_reader.sv */
module llr_block_reader
  import ldpc_cfg_pkg::*, ldpc_buf_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      out_credit,
  output logic      out_valid,
  output logic      out_par,
  output logic      out_last,
  output llr_word_t out_llr,
  output tag_t      out_tag,
  buf_rd_if.reader  rd
);

  rd_state_t          state;
  logic [cADDR_W-1:0] cnt;        // word index inside the block
  logic [cCRED_W-1:0] cred;       // credits not yet spent by out_valid
  logic               can_rd;
  logic               walking;    // fsm is inside a bank
  logic               valid_q;
  logic               par_q;
  logic               last_q;
  tag_t               tag_q;      // held after the bank is freed

  // ------------------------------------------------
  // read issue
  // ------------------------------------------------
  // word in flight will spend a credit next cycle, so keep one back for it
  assign can_rd  = rd.rbank_full & (cred > cCRED_W'(out_valid));
  assign walking = (state != RD_IDLE);

  assign rd.rd      = walking & can_rd;
  assign rd.par_sel = (state == RD_PAR) | (state == RD_CLOSE);
  assign rd.raddr   = rd.par_sel ? cnt - cADDR_W'(cDATA_WORDS) : cnt;
  assign rd.rempty  = rd.rd & (state == RD_CLOSE);    // with word 23

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RD_IDLE;
      cnt     <= '0;
      cred    <= cCRED_W'(cCREDITS);  // full pool
      valid_q <= 1'b0;
      par_q   <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      // markers line up with rdat
      valid_q <= rd.rd;
      par_q   <= rd.rd & rd.par_sel;
      last_q  <= rd.rempty;
      cred    <= cred - cCRED_W'(valid_q) + cCRED_W'(out_credit);
      if (rd.rd) begin
        cnt <= rd.rempty ? '0 : cnt + 1'b1;
      end
      case (state)
        RD_IDLE: begin
          if (rd.rbank_full) begin
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rd.rd && cnt == cADDR_W'(cDATA_WORDS - 1)) begin
            state <= RD_PAR;
          end
        end
        RD_PAR: begin
          if (rd.rd && cnt == cADDR_W'(cBLOCK_WORDS - 2)) begin
            state <= RD_CLOSE;      // one word left
          end
        end
        RD_CLOSE: begin
          if (rd.rd) begin
            state <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // tag latched at block start
  always_ff @(posedge iclk) begin
    if (state == RD_IDLE && rd.rbank_full) begin
      tag_q <= rd.rtag;
    end
  end

  assign out_valid = valid_q;
  assign out_par   = par_q;
  assign out_last  = last_q;
  assign out_llr   = rd.rdat;
  assign out_tag   = tag_q;

  // downstream must not over-return, and no word leaves without a credit
  a_cred_max: assert property (
    @(posedge iclk) disable iff (!rst_n) cred <= cCRED_W'(cCREDITS));
  a_valid_credit: assert property (
    @(posedge iclk) disable iff (!rst_n) out_valid |-> cred != '0);

endmodule

/* logic/llr_pingpong_buffer.sv */
module llr_pingpong_buffer
  import ldpc_cfg_pkg::*, ldpc_buf_pkg::*;
(
  input logic      iclk,
  input logic      rst_n,
  buf_wr_if.buffer wr,
  buf_rd_if.buffer rd
);

  logic       wbank;      // bank being filled
  logic       rbank;      // bank being drained
  logic [1:0] full;       // one flag per bank

  // storage, bank bit on top of the address
  logic [cWORD_W-1:0] dram [2*cDATA_WORDS];
  logic [cWORD_W-1:0] pram [2*cPAR_WORDS];
  tag_t               tram [2];

  logic [cWORD_W-1:0]  wdat_m;    // write data after puncturing
  logic [cDADDR_W:0]   dwaddr;
  logic [cPADDR_W:0]   pwaddr;
  logic [cDADDR_W:0]   draddr;
  logic [cPADDR_W:0]   praddr;
  logic [cWORD_W-1:0]  rdat_q;

  // ------------------------------------------------
  // bank pointers and full flags
  // ------------------------------------------------
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wbank <= 1'b0;
      rbank <= 1'b0;
      full  <= '0;      // both banks empty
    end else begin
      if (wr.wfull) begin
        full[wbank] <= 1'b1;
        wbank       <= ~wbank;
      end
      if (rd.rempty) begin
        full[rbank] <= 1'b0;    // never the bank just closed by wfull
        rbank       <= ~rbank;
      end
    end
  end

  assign wr.wbank_free = ~full[wbank];
  assign rd.rbank_full = full[rbank];   // visible the cycle after wfull

  // ------------------------------------------------
  // write port
  // ------------------------------------------------
  assign wdat_m = wr.clear ? '0 : wr.wdat;
  assign dwaddr = {wbank, wr.waddr[cDADDR_W-1:0]};
  assign pwaddr = {wbank, wr.waddr[cPADDR_W-1:0]};

  always_ff @(posedge iclk) begin
    if (wr.write) begin
      if (wr.par_sel) begin
        pram[pwaddr] <= wdat_m;
      end else begin
        dram[dwaddr] <= wdat_m;
      end
    end
    if (wr.wfull) begin
      tram[wbank] <= wr.wtag;     // tag ram written on block completion
    end
  end

  // ------------------------------------------------
  // read port, one cycle latency
  // ------------------------------------------------
  assign draddr = {rbank, rd.raddr[cDADDR_W-1:0]};
  assign praddr = {rbank, rd.raddr[cPADDR_W-1:0]};

  always_ff @(posedge iclk) begin
    if (rd.rd) begin
      rdat_q <= rd.par_sel ? pram[praddr] : dram[draddr];
    end
  end

  assign rd.rdat = rdat_q;
  assign rd.rtag = tram[rbank];   // combinational, tracks rbank

  // producer closes only a free bank, consumer frees only a full one
  a_wfull_free_bank: assert property (
    @(posedge iclk) disable iff (!rst_n) wr.wfull |-> !full[wbank]);
  a_rempty_full_bank: assert property (
    @(posedge iclk) disable iff (!rst_n) rd.rempty |-> full[rbank]);

endmodule

/* logic/llr_block_writer.sv */
module llr_block_writer
  import ldpc_cfg_pkg::*, ldpc_buf_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  llr_word_t in_llr,
  input  tag_t      in_tag,
  output logic      in_ready,
  buf_wr_if.writer  wr
);

  wr_state_t          state;
  logic [cADDR_W-1:0] cnt;        // word index inside the block
  tag_t               tag_q;      // taken with word 0
  logic               run_q;      // high from the first cycle out of reset
  logic               xfer;       // upstream handshake
  logic               last_word;

  // ------------------------------------------------
  // upstream handshake and buffer write side
  // ------------------------------------------------
  assign in_ready  = run_q & wr.wbank_free;   // stall demapper on busy bank
  assign xfer      = in_valid & in_ready;
  assign last_word = (cnt == cADDR_W'(cBLOCK_WORDS - 1));

  // write lands in the same cycle as the transfer
  assign wr.write   = xfer;
  assign wr.par_sel = (state == WR_PAR);
  assign wr.waddr   = wr.par_sel ? cnt - cADDR_W'(cDATA_WORDS) : cnt;  // parity from 0
  assign wr.clear   = (cnt < cADDR_W'(cPUNCT_WORDS));   // punctured words
  assign wr.wdat    = in_llr;
  assign wr.wtag    = tag_q;
  assign wr.wfull   = xfer & last_word;                 // with word 23

  // ------------------------------------------------
  // word sequencer
  // ------------------------------------------------
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WR_IDLE;
      cnt   <= '0;
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (xfer) begin
        cnt <= last_word ? '0 : cnt + 1'b1;   // wrap for next block
        case (state)
          WR_IDLE: state <= WR_DATA;
          WR_DATA: begin
            if (cnt == cADDR_W'(cDATA_WORDS - 1)) begin
              state <= WR_PAR;                // switch to parity ram
            end
          end
          WR_PAR: begin
            if (last_word) begin
              state <= WR_IDLE;
            end
          end
          default: state <= WR_IDLE;
        endcase
      end
    end
  end

  // block tag, sampled with the first word
  always_ff @(posedge iclk) begin
    if (xfer && state == WR_IDLE) begin
      tag_q <= in_tag;
    end
  end

  // parity phase and word counter stay in step on every write
  a_phase_cnt: assert property (
    @(posedge iclk) disable iff (!rst_n)
    wr.write |-> wr.par_sel == (cnt >= cADDR_W'(cDATA_WORDS)));

endmodule

/* logic/ldpc_buf_if.sv */
// producer -> ping-pong buffer
interface buf_wr_if import ldpc_cfg_pkg::*, ldpc_buf_pkg::*; ();

  logic               write;      // store wdat this cycle
  logic               par_sel;    // 1 = parity ram
  logic [cADDR_W-1:0] waddr;      // address inside the selected ram
  logic               clear;      // store zero instead of wdat
  llr_word_t          wdat;
  tag_t               wtag;
  logic               wfull;      // last write of a block, closes the bank
  logic               wbank_free; // current write bank may take data

  modport writer (output write, par_sel, waddr, clear, wdat, wtag, wfull,
                  input  wbank_free);
  modport buffer (input  write, par_sel, waddr, clear, wdat, wtag, wfull,
                  output wbank_free);

endinterface

// ping-pong buffer -> consumer
interface buf_rd_if import ldpc_cfg_pkg::*, ldpc_buf_pkg::*; ();

  logic               rd;         // read strobe, rdat valid next cycle
  logic               par_sel;
  logic [cADDR_W-1:0] raddr;
  logic               rempty;     // last read, frees the bank
  logic               rbank_full; // current read bank holds a block
  llr_word_t          rdat;
  tag_t               rtag;       // tag of current read bank, no delay

  modport reader (output rd, par_sel, raddr, rempty,
                  input  rbank_full, rdat, rtag);
  modport buffer (input  rd, par_sel, raddr, rempty,
                  output rbank_full, rdat, rtag);

endinterface

/* logic/ldpc_buf_pkg.sv */
package ldpc_buf_pkg;

  import ldpc_cfg_pkg::*;

  // ------------------------------------------------
  // payload types
  // ------------------------------------------------
  typedef logic signed [cLLR_W-1:0] llr_t;          // one soft decision
  typedef llr_t [cLLR_PER_WORD-1:0] llr_word_t;     // llr 0 sits in the low bits
  typedef logic [cTAG_W-1:0]        tag_t;          // block tag, travels with the block

  // ------------------------------------------------
  // fsm states
  // ------------------------------------------------
  // producer side
  typedef enum logic [1:0] {
    WR_IDLE,    // waiting for word 0
    WR_DATA,    // words 1..15
    WR_PAR      // words 16..23
  } wr_state_t;

  // consumer side, close state reads the final word and frees the bank
  typedef enum logic [1:0] {
    RD_IDLE, RD_DATA, RD_PAR, RD_CLOSE
  } rd_state_t;

endpackage

/* logic/ldpc_cfg_pkg.sv */
package ldpc_cfg_pkg;

  // ------------------------------------------------
  // llr word geometry
  // ------------------------------------------------
  localparam int cLLR_W        = 5;                         // bits per soft bit
  localparam int cLLR_PER_WORD = 4;                         // llrs per bus word
  localparam int cWORD_W       = cLLR_W * cLLR_PER_WORD;    // 20

  // ------------------------------------------------
  // block and buffer geometry
  // ------------------------------------------------
  localparam int cDATA_WORDS  = 16;
  localparam int cPAR_WORDS   = 8;
  localparam int cBLOCK_WORDS = cDATA_WORDS + cPAR_WORDS;   // 24
  localparam int cPUNCT_WORDS = 2;                          // leading words stored as zero
  localparam int cADDR_W      = 5;                          // word index inside a block
  localparam int cDADDR_W     = $clog2(cDATA_WORDS);        // data ram, per bank
  localparam int cPADDR_W     = $clog2(cPAR_WORDS);         // parity ram, per bank
  localparam int cTAG_W       = 8;
  // downstream flow control
  localparam int cCREDITS     = 4;
  localparam int cCRED_W      = $clog2(cCREDITS + 1);       // counts 0..cCREDITS

endpackage
